// File: include/int_div_config.svh
// ------------------------------
// divider sizing, the step count must equal the operand width
// the counter must be wide enough to hold DIV_STEPS - 1
// ------------------------------

`ifndef INT_DIV_CONFIG_SVH
`define INT_DIV_CONFIG_SVH

// operand and result width in bits
`define DIV_XLEN 32

// step counter width, holds 0 .. DIV_STEPS-1
`define DIV_CNT_W 6

// one restoring iteration per quotient bit
`define DIV_STEPS `DIV_XLEN

`endif

// File: src/int_div_pkg.sv
// ------------------------------
// shared types for the iterative divider
// field widths follow DIV_XLEN from the config header
// ------------------------------

`include "int_div_config.svh"

package int_div_pkg;

  // division function carried with each request
  typedef enum logic {
    DIV_FN_UNSIGNED = 1'b0,
    DIV_FN_SIGNED   = 1'b1
  } div_fn_e;

  // control fsm states
  typedef enum logic [1:0] {
    DIV_IDLE = 2'd0,
    DIV_CALC = 2'd1,
    DIV_DONE = 2'd2
  } div_state_e;

  // request message, fn then dividend then divisor
  typedef struct packed {
    div_fn_e             fn;
    logic [`DIV_XLEN-1:0] a;
    logic [`DIV_XLEN-1:0] b;
  } div_req_t;

  // response message, remainder in the upper half
  typedef struct packed {
    logic [`DIV_XLEN-1:0] rem;
    logic [`DIV_XLEN-1:0] quot;
  } div_resp_t;

  // result signs captured on accept
  typedef struct packed {
    logic quot_neg;
    logic rem_neg;
  } div_sign_t;

  // per-cycle datapath commands from the fsm
  typedef struct packed {
    logic load;
    logic step;
  } div_ctrl_t;

endpackage

// File: src/div_ctrl.sv
// ------------------------------
// idle/calc/done fsm, one request in flight at a time
// load is combinational on req_val, step lasts DIV_STEPS cycles
// ------------------------------

`timescale 1ns/1ns

`include "int_div_config.svh"

module div_ctrl (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   req_val,
  input  logic                   resp_rdy,
  output logic                   req_rdy,
  output logic                   resp_val,
  output int_div_pkg::div_ctrl_t ctrl
);

  // count value seen in the final calc cycle
  localparam logic [`DIV_CNT_W-1:0] last_cnt = `DIV_CNT_W'(`DIV_STEPS - 1);

  int_div_pkg::div_state_e state;
  int_div_pkg::div_state_e state_next;
  logic [`DIV_CNT_W-1:0]   count;
  logic                    last_step;
  logic                    req_go;
  logic                    resp_go;

  // ------------------------------
  // handshake
  // ------------------------------

  assign req_rdy  = (state == int_div_pkg::DIV_IDLE);
  assign resp_val = (state == int_div_pkg::DIV_DONE);
  assign req_go   = req_val & req_rdy;
  assign resp_go  = resp_val & resp_rdy;

  assign last_step = (count == last_cnt);

  always_comb begin
    ctrl.load = req_go;
    ctrl.step = (state == int_div_pkg::DIV_CALC);
  end

  // ------------------------------
  // next state
  // ------------------------------

  always_comb begin
    state_next = state;
    case (state)
      int_div_pkg::DIV_IDLE: begin
        if (req_go) begin
          state_next = int_div_pkg::DIV_CALC;
        end
      end
      int_div_pkg::DIV_CALC: begin
        if (last_step) begin
          state_next = int_div_pkg::DIV_DONE;
        end
      end
      int_div_pkg::DIV_DONE: begin
        // hold the response until the consumer takes it
        if (resp_go) begin
          state_next = int_div_pkg::DIV_IDLE;
        end
      end
      default: state_next = int_div_pkg::DIV_IDLE;
    endcase
  end

  // ------------------------------
  // state and step counter
  // ------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= int_div_pkg::DIV_IDLE;
      count <= '0;
    end else begin
      state <= state_next;
      // counts calc cycles, wraps to zero on the last one
      if (ctrl.step && !last_step) begin
        count <= count + 1'b1;
      end else begin
        count <= '0;
      end
    end
  end

  // ------------------------------
  // checks
  // ------------------------------

  a_rdy_val_excl: assert property (
    @(posedge clk) disable iff (reset)
    !(req_rdy && resp_val)
  ) else $error("req_rdy and resp_val high together");

  a_count_range: assert property (
    @(posedge clk) disable iff (reset)
    count <= last_cnt
  ) else $error("step counter past last step");

  // back-pressure must not drop a finished result
  a_done_hold: assert property (
    @(posedge clk) disable iff (reset)
    (state == int_div_pkg::DIV_DONE && !resp_rdy) |=> (state == int_div_pkg::DIV_DONE)
  ) else $error("left done without a response transfer");

endmodule

// File: src/div_sign_unit.sv
// ------------------------------
// sign handling around the unsigned core
// req must be stable in the cycle where ctrl.load is high
// ------------------------------

`timescale 1ns/1ns

`include "int_div_config.svh"

module div_sign_unit (
  input  logic                   clk,
  input  logic                   reset,
  input  int_div_pkg::div_req_t  req,
  input  int_div_pkg::div_ctrl_t ctrl,
  input  logic [`DIV_XLEN-1:0]   raw_quot,
  input  logic [`DIV_XLEN-1:0]   raw_rem,
  output logic [`DIV_XLEN-1:0]   a_mag,
  output logic [`DIV_XLEN-1:0]   b_mag,
  output int_div_pkg::div_resp_t resp
);

  // ------------------------------
  // operand magnitudes
  // ------------------------------

  logic is_signed;
  logic a_neg;
  logic b_neg;

  // only a signed request treats the top bit as a sign
  assign is_signed = (req.fn == int_div_pkg::DIV_FN_SIGNED);
  assign a_neg     = is_signed & req.a[`DIV_XLEN-1];
  assign b_neg     = is_signed & req.b[`DIV_XLEN-1];

  // two's complement negate, -2^31 maps onto itself
  // which is still the right unsigned magnitude
  assign a_mag = a_neg ? (~req.a + 1'b1) : req.a;
  assign b_mag = b_neg ? (~req.b + 1'b1) : req.b;

  // ------------------------------
  // result sign register
  // ------------------------------

  int_div_pkg::div_sign_t sign_next;
  int_div_pkg::div_sign_t sign_q;

  always_comb begin
    // quotient is negative when exactly one operand is
    sign_next.quot_neg = a_neg ^ b_neg;
    // remainder takes the sign of the dividend
    sign_next.rem_neg  = a_neg;
  end

  // captured once per request, held through calc and done
  always_ff @(posedge clk) begin
    if (reset) begin
      sign_q <= '0;
    end else if (ctrl.load) begin
      sign_q <= sign_next;
    end
  end

  // ------------------------------
  // output correction
  // ------------------------------

  // purely combinational so resp follows the core register directly
  // and stays put while the core holds in done
  always_comb begin
    resp.quot = sign_q.quot_neg ? (~raw_quot + 1'b1) : raw_quot;
    resp.rem  = sign_q.rem_neg ? (~raw_rem + 1'b1) : raw_rem;
  end

endmodule

// File: src/div_step_dpath.sv
// ------------------------------
// restoring shift-subtract core, one quotient bit per step
// divide by zero yields all-ones quotient and rem = dividend
// ------------------------------

`timescale 1ns/1ns

`include "int_div_config.svh"

module div_step_dpath (
  input  logic                   clk,
  input  logic                   reset,
  input  int_div_pkg::div_ctrl_t ctrl,
  input  logic [`DIV_XLEN-1:0]   a_mag,
  input  logic [`DIV_XLEN-1:0]   b_mag,
  output logic [`DIV_XLEN-1:0]   raw_quot,
  output logic [`DIV_XLEN-1:0]   raw_rem
);

  // one guard bit above the partial remainder
  localparam int rq_w = 2 * `DIV_XLEN + 1;

  // layout of rq_q
  //   [64]    guard bit
  //   [63:32] partial remainder
  //   [31:0]  dividend bits still to shift, then quotient bits
  logic [rq_w-1:0] rq_q;
  logic [rq_w-1:0] divisor_q;

  logic [rq_w-1:0] rq_shift;
  logic [rq_w-1:0] rq_diff;
  logic [rq_w-1:0] rq_step;

  // ------------------------------
  // one iteration
  // ------------------------------

  // shift left, lsb opens a slot for the new quotient bit
  assign rq_shift = {rq_q[rq_w-2:0], 1'b0};

  // divisor sits on the remainder half, so low bits pass through
  assign rq_diff = rq_shift - divisor_q;

  // guard bit set means the trial subtract went negative
  // so restore the shifted value and record a zero
  assign rq_step = rq_diff[rq_w-1] ? rq_shift : {rq_diff[rq_w-1:1], 1'b1};

  // ------------------------------
  // registers
  // ------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      rq_q <= '0;
    end else if (ctrl.load) begin
      rq_q <= {{(`DIV_XLEN + 1){1'b0}}, a_mag};
    end else if (ctrl.step) begin
      rq_q <= rq_step;
    end
  end

  // divisor is only written on accept
  always_ff @(posedge clk) begin
    if (ctrl.load) begin
      divisor_q <= {1'b0, b_mag, {`DIV_XLEN{1'b0}}};
    end
  end

  assign raw_rem  = rq_q[2*`DIV_XLEN-1:`DIV_XLEN];
  assign raw_quot = rq_q[`DIV_XLEN-1:0];

  // ------------------------------
  // checks
  // ------------------------------

  // a reload in the middle of a division would corrupt the result
  a_divisor_stable: assert property (
    @(posedge clk) disable iff (reset)
    ctrl.step |=> $stable(divisor_q)
  ) else $error("divisor register changed during calc");

endmodule

// File: src/int_div_iterative.sv
// ------------------------------
// 32-bit iterative divider, val/rdy request and response
// resp_val rises 33 cycles after accept, resp is {rem, quot}
// ------------------------------

`timescale 1ns/1ns

`include "int_div_config.svh"

module int_div_iterative (
  input  logic                   clk,
  input  logic                   reset,
  input  int_div_pkg::div_req_t  req,
  input  logic                   req_val,
  output logic                   req_rdy,
  output int_div_pkg::div_resp_t resp,
  output logic                   resp_val,
  input  logic                   resp_rdy
);

  int_div_pkg::div_ctrl_t ctrl;

  // unsigned operands into the core
  logic [`DIV_XLEN-1:0] a_mag;
  logic [`DIV_XLEN-1:0] b_mag;

  // core results before sign correction
  logic [`DIV_XLEN-1:0] raw_quot;
  logic [`DIV_XLEN-1:0] raw_rem;

  div_ctrl ctrl0 (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .resp_rdy (resp_rdy),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .ctrl     (ctrl)
  );

  div_sign_unit sign0 (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .ctrl     (ctrl),
    .raw_quot (raw_quot),
    .raw_rem  (raw_rem),
    .a_mag    (a_mag),
    .b_mag    (b_mag),
    .resp     (resp)
  );

  div_step_dpath step0 (
    .clk      (clk),
    .reset    (reset),
    .ctrl     (ctrl),
    .a_mag    (a_mag),
    .b_mag    (b_mag),
    .raw_quot (raw_quot),
    .raw_rem  (raw_rem)
  );

endmodule

// File: tb/int_div_iterative_tb.sv
// ------------------------------
// self-checking testbench, fixed table then seeded random requests
// one request in flight, resp_rdy held low for a per-test count
// ------------------------------

`timescale 1ns/1ns

`include "int_div_config.svh"

module int_div_iterative_tb;

  localparam int xw     = `DIV_XLEN;
  localparam int n_tab  = 10;
  localparam int n_rand = 20;
  localparam int max_wait = 100;

  logic                   clk;
  logic                   reset;
  int_div_pkg::div_req_t  req;
  logic                   req_val;
  logic                   req_rdy;
  int_div_pkg::div_resp_t resp;
  logic                   resp_val;
  logic                   resp_rdy;

  // stimulus table, one row per directed test
  string                 tab_name [n_tab];
  int_div_pkg::div_fn_e  tab_fn   [n_tab];
  logic [xw-1:0]         tab_a    [n_tab];
  logic [xw-1:0]         tab_b    [n_tab];
  logic [xw-1:0]         tab_q    [n_tab];
  logic [xw-1:0]         tab_r    [n_tab];
  int                    tab_bp   [n_tab];

  int     pass_count;
  int     fail_count;
  integer seed;

  int_div_iterative dut0 (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  always #5 clk = ~clk;

  task automatic set_case(input int i, input string name, input int_div_pkg::div_fn_e fn,
      input logic [xw-1:0] a, input logic [xw-1:0] b,
      input logic [xw-1:0] q, input logic [xw-1:0] r, input int bp);
    tab_name[i] = name;
    tab_fn[i]   = fn;
    tab_a[i]    = a;
    tab_b[i]    = b;
    tab_q[i]    = q;
    tab_r[i]    = r;
    tab_bp[i]   = bp;
  endtask

  // expected {rem, quot} from magnitudes, restoring rule and sign fix
  function automatic logic [2*xw-1:0] ref_div(input int_div_pkg::div_fn_e fn,
      input logic [xw-1:0] a, input logic [xw-1:0] b);
    logic          a_neg;
    logic          b_neg;
    logic [xw-1:0] am;
    logic [xw-1:0] bm;
    logic [xw-1:0] q;
    logic [xw-1:0] r;
    a_neg = (fn == int_div_pkg::DIV_FN_SIGNED) && a[xw-1];
    b_neg = (fn == int_div_pkg::DIV_FN_SIGNED) && b[xw-1];
    am = a_neg ? -a : a;
    bm = b_neg ? -b : b;
    // zero divisor, every trial subtract succeeds
    if (bm == '0) begin
      q = '1;
      r = am;
    end else begin
      q = am / bm;
      r = am % bm;
    end
    if (a_neg ^ b_neg) q = -q;
    if (a_neg) r = -r;
    return {r, q};
  endfunction

  task automatic tally(input string name, input int errs);
    if (errs == 0) begin
      pass_count++;
      $display("pass %s", name);
    end else begin
      fail_count++;
      $display("fail %s", name);
    end
  endtask

  // one request through accept, calc, back-pressure and transfer
  task automatic run_test(input string name, input int_div_pkg::div_fn_e fn,
      input logic [xw-1:0] a, input logic [xw-1:0] b,
      input logic [xw-1:0] exp_q, input logic [xw-1:0] exp_r, input int bp);
    int                     errs;
    int                     lat;
    int_div_pkg::div_resp_t first;
    errs = 0;
    lat  = 0;
    @(posedge clk);
    #1;
    req.fn  = fn;
    req.a   = a;
    req.b   = b;
    req_val = 1'b1;
    @(negedge clk);
    while (!req_rdy && lat < max_wait) begin
      @(negedge clk);
      lat++;
    end
    if (!req_rdy) begin
      errs++;
      $display("%s: request never accepted, fsm state %0d", name, dut0.ctrl0.state);
    end else begin
      // this edge is the accept edge
      @(posedge clk);
      #1;
      req_val = 1'b0;
      req     = '0;
      lat     = 0;
      while (!resp_val && lat < max_wait) begin
        @(negedge clk);
        lat++;
      end
      if (!resp_val) begin
        errs++;
        $display("%s: no response after %0d cycles, fsm state %0d", name, lat,
                 dut0.ctrl0.state);
      end else begin
        if (lat != `DIV_STEPS + 1) begin
          errs++;
          $display("%s: response came %0d cycles after accept instead of %0d", name, lat,
                   `DIV_STEPS + 1);
        end
        first = resp;
        // consumer stalls, response must hold still
        repeat (bp) begin
          @(negedge clk);
          if (!resp_val || req_rdy || resp !== first) begin
            errs++;
            $display("%s: response not held under back-pressure", name);
          end
        end
        if (first.quot !== exp_q) begin
          errs++;
          $display("mismatch %s quot expected %h actual %h", name, exp_q, first.quot);
        end
        if (first.rem !== exp_r) begin
          errs++;
          $display("mismatch %s rem expected %h actual %h", name, exp_r, first.rem);
        end
        @(posedge clk);
        #1;
        resp_rdy = 1'b1;
        @(posedge clk);
        #1;
        resp_rdy = 1'b0;
        @(negedge clk);
        if (!req_rdy || resp_val) begin
          errs++;
          $display("%s: divider not back in idle the cycle after the transfer", name);
        end
      end
    end
    tally(name, errs);
  endtask

  // limit scales with test count and the longest stall in the table
  initial begin
    int max_bp;
    int limit;
    max_bp = 0;
    #1;
    for (int i = 0; i < n_tab; i++) begin
      if (tab_bp[i] > max_bp) max_bp = tab_bp[i];
    end
    limit = (n_tab + n_rand + 1) * (40 + max_bp) + 8;
    repeat (limit) @(posedge clk);
    $display("timeout after %0d cycles, fsm state %0d", limit, dut0.ctrl0.state);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    logic [xw-1:0]        ra;
    logic [xw-1:0]        rb;
    logic [31:0]          rbits;
    logic [2*xw-1:0]      exp;
    int_div_pkg::div_fn_e rfn;
    int                   errs;
    clk        = 1'b0;
    reset      = 1'b1;
    req        = '0;
    req_val    = 1'b0;
    resp_rdy   = 1'b0;
    pass_count = 0;
    fail_count = 0;
    seed       = 26755;
    set_case(0, "u_100_7", int_div_pkg::DIV_FN_UNSIGNED, 32'd100, 32'd7, 32'd14, 32'd2, 0);
    set_case(1, "u_max_1", int_div_pkg::DIV_FN_UNSIGNED, 32'hFFFFFFFF, 32'd1,
             32'hFFFFFFFF, 32'd0, 0);
    set_case(2, "u_5_9", int_div_pkg::DIV_FN_UNSIGNED, 32'd5, 32'd9, 32'd0, 32'd5, 3);
    set_case(3, "s_m7_2", int_div_pkg::DIV_FN_SIGNED, 32'hFFFFFFF9, 32'd2,
             32'hFFFFFFFD, 32'hFFFFFFFF, 0);
    set_case(4, "s_7_m2", int_div_pkg::DIV_FN_SIGNED, 32'd7, 32'hFFFFFFFE,
             32'hFFFFFFFD, 32'd1, 0);
    set_case(5, "s_m7_m2", int_div_pkg::DIV_FN_SIGNED, 32'hFFFFFFF9, 32'hFFFFFFFE,
             32'd3, 32'hFFFFFFFF, 5);
    set_case(6, "u_div0", int_div_pkg::DIV_FN_UNSIGNED, 32'd1234, 32'd0,
             32'hFFFFFFFF, 32'd1234, 0);
    // all-ones magnitude negated, remainder keeps the dividend sign
    set_case(7, "s_m9_div0", int_div_pkg::DIV_FN_SIGNED, 32'hFFFFFFF7, 32'd0,
             32'd1, 32'hFFFFFFF7, 1);
    set_case(8, "s_min_m1", int_div_pkg::DIV_FN_SIGNED, 32'h80000000, 32'hFFFFFFFF,
             32'h80000000, 32'd0, 2);
    set_case(9, "u_min_max", int_div_pkg::DIV_FN_UNSIGNED, 32'h80000000, 32'hFFFFFFFF,
             32'd0, 32'h80000000, 0);
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    // ----- state right after reset -----
    @(negedge clk);
    errs = 0;
    if (!req_rdy || resp_val) begin
      errs++;
      $display("reset_state: req_rdy not high or resp_val not low after reset");
    end
    tally("reset_state", errs);
    // ----- directed table -----
    for (int i = 0; i < n_tab; i++) begin
      run_test(tab_name[i], tab_fn[i], tab_a[i], tab_b[i], tab_q[i], tab_r[i], tab_bp[i]);
    end
    // ----- random requests -----
    for (int i = 0; i < n_rand; i++) begin
      ra    = $random(seed);
      rb    = $random(seed);
      rbits = $random(seed);
      rfn   = int_div_pkg::div_fn_e'(rbits[0]);
      exp   = ref_div(rfn, ra, rb);
      run_test($sformatf("rand_%0d", i), rfn, ra, rb, exp[xw-1:0], exp[2*xw-1:xw], 0);
    end
    $display("tests %0d passed %0d failed %0d", pass_count + fail_count, pass_count,
             fail_count);
    if (fail_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+include
src/int_div_pkg.sv
src/div_ctrl.sv
src/div_sign_unit.sv
src/div_step_dpath.sv
src/int_div_iterative.sv
tb/int_div_iterative_tb.sv

// File: Bender.yml
package:
  name: int_div_iterative

sources:
  - include_dirs:
      - include
    files:
      - src/int_div_pkg.sv
      - src/div_ctrl.sv
      - src/div_sign_unit.sv
      - src/div_step_dpath.sv
      - src/int_div_iterative.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - tb/int_div_iterative_tb.sv
